// ==== rtl/dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Instruction queue size and pointer width
`define DISPATCH_IQ_DEPTH 16
`define DISPATCH_IQ_IDX_W 4

// Occupancy at which iq_full rises, leaving one slot of margin
`define DISPATCH_IQ_FULL_AT 15

// Opcode of a bubble word, never stored in the queue
`define DISPATCH_NOP_OP 5'd31

`endif

// ==== rtl/isa_pkg.sv ====
`include "dispatch_settings.svh"

package isa_pkg;

    typedef logic [4:0] opcode_t;
    typedef logic [4:0] reg_idx_t;

    // Register form: opcodes 0 to 15
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] unused;
    } insn_r_t;

    // Immediate form: opcodes 16 to 30, rs2 slot holds the immediate
    typedef struct packed {
        opcode_t            opcode;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        logic signed [16:0] imm;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_word_u;

    typedef enum logic [1:0] {
        OPC_REG,
        OPC_IMM,
        OPC_NOP
    } opc_class_e;

    localparam opcode_t OP_REG_LAST  = 5'd15;
    localparam opcode_t OP_IMM_FIRST = 5'd16;

    function automatic opc_class_e opcode_class(opcode_t op);
        opc_class_e cls;
        cls = OPC_NOP;
        if (op <= OP_REG_LAST) begin
            cls = OPC_REG;
        end else if (op >= OP_IMM_FIRST && op != `DISPATCH_NOP_OP) begin
            cls = OPC_IMM;
        end
        return cls;
    endfunction

endpackage

// ==== rtl/dispatch_pkg.sv ====
`include "dispatch_settings.svh"

package dispatch_pkg;

    typedef logic [`DISPATCH_IQ_IDX_W-1:0] iq_idx_t;

    // Decoded micro-op as held in the queue and sent to issue
    typedef struct packed {
        isa_pkg::opcode_t  op;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
        logic [31:0]       imm;
        logic              has_imm;
    } micro_op_t;

    // Empty slot in the issue registers
    localparam micro_op_t UOP_BUBBLE = '{
        op:      `DISPATCH_NOP_OP,
        rs1:     '0,
        rs2:     '0,
        rd:      '0,
        imm:     '0,
        has_imm: 1'b0
    };

endpackage

// ==== rtl/insn_decoder.sv ====
module insn_decoder (
    input  isa_pkg::insn_word_u     insn,
    output dispatch_pkg::micro_op_t uop,
    output logic                    uop_valid
);
    import isa_pkg::*;
    import dispatch_pkg::*;

    opc_class_e cls;

    // Opcode sits in the same bits in both views
    assign cls = opcode_class(insn.r.opcode);

    assign uop_valid = (cls != OPC_NOP);

    always_comb begin
        uop = UOP_BUBBLE;
        case (cls)
            OPC_REG: begin
                uop.op      = insn.r.opcode;
                uop.rd      = insn.r.rd;
                uop.rs1     = insn.r.rs1;
                uop.rs2     = insn.r.rs2;
                uop.imm     = '0;
                uop.has_imm = 1'b0;
            end
            OPC_IMM: begin
                uop.op      = insn.i.opcode;
                uop.rd      = insn.i.rd;
                uop.rs1     = insn.i.rs1;
                uop.rs2     = '0;
                // Sign-extend the 17-bit field to a full word
                uop.imm     = {{15{insn.i.imm[16]}}, insn.i.imm};
                uop.has_imm = 1'b1;
            end
            default: begin
                uop = UOP_BUBBLE;
            end
        endcase
    end

endmodule

// ==== rtl/iq_storage.sv ====
`include "dispatch_settings.svh"

module iq_storage (
    input  logic                    clk,
    input  logic                    wr_en,
    input  dispatch_pkg::iq_idx_t   wr_idx,
    input  dispatch_pkg::micro_op_t wr_uop,
    input  dispatch_pkg::iq_idx_t   rd_idx,
    output dispatch_pkg::micro_op_t head_uop
);
    import dispatch_pkg::*;

    micro_op_t entries [`DISPATCH_IQ_DEPTH];

    // Entry contents only matter while counted as occupied by the control
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_idx] <= wr_uop;
        end
    end

    // Head is read combinationally so pop can load it in the same cycle
    assign head_uop = entries[rd_idx];

endmodule

// ==== rtl/dispatch_ctrl.sv ====
`include "dispatch_settings.svh"

module dispatch_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pause,
    input  logic                  uop_valid,
    input  logic                  rs_full,
    input  logic                  rob_full,
    output logic                  wr_en,
    output dispatch_pkg::iq_idx_t wr_idx,
    output dispatch_pkg::iq_idx_t rd_idx,
    output logic                  pop,
    output logic                  stage_en,
    output logic                  iq_full
);
    import dispatch_pkg::*;

    localparam int CNT_W = `DISPATCH_IQ_IDX_W + 1;

    localparam logic [CNT_W-1:0] CNT_DEPTH   = CNT_W'(`DISPATCH_IQ_DEPTH);
    localparam logic [CNT_W-1:0] CNT_FULL_AT = CNT_W'(`DISPATCH_IQ_FULL_AT);

    iq_idx_t          head_q;
    iq_idx_t          tail_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             empty;
    logic             at_cap;

    assign empty  = (count_q == '0);
    assign at_cap = (count_q == CNT_DEPTH);

    // A valid word with no free slot is dropped
    assign wr_en = uop_valid && !at_cap && !pause;

    // Either full flag holds the head in place
    assign pop = !empty && !rs_full && !rob_full && !pause;

    // Issue registers advance every unpaused cycle, bubbles included
    assign stage_en = !pause;

    assign wr_idx = tail_q;
    assign rd_idx = head_q;

    assign count_d = count_q + CNT_W'(wr_en) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            iq_full <= 1'b0;
        end else if (!pause) begin
            if (wr_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_d;
            iq_full <= (count_d >= CNT_FULL_AT);
        end
    end

endmodule

// ==== rtl/issue_stage.sv ====
module issue_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stage_en,
    input  logic                    pop,
    input  dispatch_pkg::micro_op_t head_uop,
    output dispatch_pkg::micro_op_t uop_out,
    output logic                    issued
);
    import dispatch_pkg::*;

    micro_op_t stage_q;
    logic      stage_vld_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_q     <= UOP_BUBBLE;
            stage_vld_q <= 1'b0;
            uop_out     <= UOP_BUBBLE;
            issued      <= 1'b0;
        end else if (stage_en) begin
            if (pop) begin
                stage_q     <= head_uop;
                stage_vld_q <= 1'b1;
            end else begin
                stage_q     <= UOP_BUBBLE;
                stage_vld_q <= 1'b0;
            end
            // Whatever was staged moves out regardless of back-pressure
            uop_out <= stage_q;
            issued  <= stage_vld_q;
        end
    end

endmodule

// ==== rtl/dispatch_top.sv ====
module dispatch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pause,
    input  isa_pkg::insn_word_u     insn,
    input  logic                    rs_full,
    input  logic                    rob_full,
    output logic                    iq_full,
    output dispatch_pkg::micro_op_t uop_out,
    output logic                    issued
);
    import dispatch_pkg::*;

    micro_op_t uop;
    logic      uop_valid;
    logic      wr_en;
    iq_idx_t   wr_idx;
    iq_idx_t   rd_idx;
    logic      pop;
    logic      stage_en;
    micro_op_t head_uop;

    insn_decoder decoder_i (
        .insn      (insn),
        .uop       (uop),
        .uop_valid (uop_valid)
    );

    dispatch_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .pause     (pause),
        .uop_valid (uop_valid),
        .rs_full   (rs_full),
        .rob_full  (rob_full),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .rd_idx    (rd_idx),
        .pop       (pop),
        .stage_en  (stage_en),
        .iq_full   (iq_full)
    );

    iq_storage storage_i (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_uop   (uop),
        .rd_idx   (rd_idx),
        .head_uop (head_uop)
    );

    issue_stage issue_i (
        .clk      (clk),
        .rst      (rst),
        .stage_en (stage_en),
        .pop      (pop),
        .head_uop (head_uop),
        .uop_out  (uop_out),
        .issued   (issued)
    );

endmodule

// ==== tests/dispatch_assertions.sv ====
`include "dispatch_settings.svh"

module dispatch_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    pause,
    input logic                    rs_full,
    input logic                    rob_full,
    input logic                    iq_full,
    input logic                    issued,
    input dispatch_pkg::micro_op_t uop_out
);
    timeunit 1ns;
    timeprecision 100ps;

    import dispatch_pkg::*;

    int   fail_count = 0;
    logic issue_slot;

    // An edge at which the head may leave the queue
    assign issue_slot = !pause && !rs_full && !rob_full;

    reset_state: assert property (@(posedge clk)
        !rst |=> (!iq_full && !issued && uop_out == UOP_BUBBLE))
        else begin
            fail_count++;
            $error("outputs not cleared by reset");
        end

    // A frozen front end keeps every output where it was
    pause_hold: assert property (@(posedge clk) disable iff (!rst)
        pause |=> ($stable(uop_out) && $stable(issued) && $stable(iq_full)))
        else begin
            fail_count++;
            $error("outputs changed while paused");
        end

    // Two unpaused edges back, the pop for this micro-op needed a free slot
    issue_needs_slot: assert property (@(posedge clk) disable iff (!rst)
        (issued && $past(!pause) && $past(!pause, 2)) |-> $past(issue_slot, 2))
        else begin
            fail_count++;
            $error("micro-op issued without a pop slot two edges earlier");
        end

    no_bubble_issued: assert property (@(posedge clk) disable iff (!rst)
        issued |-> (uop_out.op != `DISPATCH_NOP_OP))
        else begin
            fail_count++;
            $error("bubble opcode shown as issued");
        end

endmodule

bind dispatch_top dispatch_assertions asrt_i (
    .clk      (clk),
    .rst      (rst),
    .pause    (pause),
    .rs_full  (rs_full),
    .rob_full (rob_full),
    .iq_full  (iq_full),
    .issued   (issued),
    .uop_out  (uop_out)
);

// ==== tests/dispatch_tb.sv ====
`include "dispatch_settings.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import dispatch_pkg::*;

    localparam int RAND_WORDS     = 400;
    // Latency word, overflow burst, pause fill and words shown during pause
    localparam int DIRECTED_WORDS = 1 + 17 + 3 + 4;
    localparam int TIMEOUT_CYCLES = 20 * (RAND_WORDS + DIRECTED_WORDS) + 200;
    localparam int DRAIN_LIMIT    = 2 * `DISPATCH_IQ_DEPTH + 8;

    localparam logic [31:0] NOP_WORD = {`DISPATCH_NOP_OP, 27'd0};

    logic       clk;
    logic       rst;
    logic       pause;
    insn_word_u insn;
    logic       rs_full;
    logic       rob_full;
    logic       iq_full;
    micro_op_t  uop_out;
    logic       issued;

    logic [31:0] lfsr;
    micro_op_t   model_q[$];
    int          occ_m;
    logic        stg_vld_m;
    logic        out_vld_m;
    int          mismatches;
    int          failures;
    int          issue_count;
    int          cycle_count;

    dispatch_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .pause    (pause),
        .insn     (insn),
        .rs_full  (rs_full),
        .rob_full (rob_full),
        .iq_full  (iq_full),
        .uop_out  (uop_out),
        .issued   (issued)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic is_bubble(logic [31:0] w);
        return w[31:27] == `DISPATCH_NOP_OP;
    endfunction

    // Expected micro-op built straight from the raw bit fields
    function automatic micro_op_t expect_uop(logic [31:0] w);
        micro_op_t u;
        u.op  = w[31:27];
        u.rd  = w[26:22];
        u.rs1 = w[21:17];
        if (w[31:27] < 5'd16) begin
            u.rs2     = w[16:12];
            u.imm     = 32'd0;
            u.has_imm = 1'b0;
        end else begin
            u.rs2     = 5'd0;
            u.imm     = {{15{w[16]}}, w[16:0]};
            u.has_imm = 1'b1;
        end
        return u;
    endfunction

    function automatic logic [31:0] random_word();
        logic [4:0] op;
        op = 5'(next_bits(5));
        // About one word in eight becomes a bubble
        if (next_bits(3) == 32'd0) begin
            op = `DISPATCH_NOP_OP;
        end
        return {op, 27'(next_bits(27))};
    endfunction

    function automatic logic [31:0] valid_word();
        logic [31:0] w;
        w = random_word();
        if (is_bubble(w)) begin
            w[31:27] = 5'd20;
        end
        return w;
    endfunction

    task automatic report_mismatch(string msg);
        mismatches++;
        $display("mismatch at %0d ns: %s", $time, msg);
    endtask

    task automatic check_outputs(input logic paused);
        if (issued !== out_vld_m) begin
            report_mismatch($sformatf("issued %b, expected %b", issued, out_vld_m));
        end
        if (iq_full !== (occ_m >= `DISPATCH_IQ_FULL_AT)) begin
            report_mismatch($sformatf("iq_full %b with %0d entries queued", iq_full, occ_m));
        end
        if (!paused && issued === 1'b1) begin
            if (model_q.size() == 0) begin
                failures++;
                $display("a micro-op issued at %0d ns when none was expected", $time);
            end else begin
                if (uop_out !== model_q[0]) begin
                    report_mismatch($sformatf("uop_out %h, expected %h", uop_out, model_q[0]));
                end
                void'(model_q.pop_front());
                issue_count++;
            end
        end
        if (issued === 1'b0 && uop_out.op !== `DISPATCH_NOP_OP) begin
            report_mismatch($sformatf("uop_out.op %0d while not issued", uop_out.op));
        end
    endtask

    // Starts on a falling edge and returns on the next falling edge
    task automatic apply_cycle(input logic [31:0] word, input logic p,
                               input logic rs, input logic rob);
        logic pop_m;
        logic acc_m;
        insn     = word;
        pause    = p;
        rs_full  = rs;
        rob_full = rob;
        @(negedge clk);
        if (!p) begin
            pop_m     = (occ_m != 0) && !rs && !rob;
            acc_m     = !is_bubble(word) && (occ_m < `DISPATCH_IQ_DEPTH);
            out_vld_m = stg_vld_m;
            stg_vld_m = pop_m;
            if (acc_m) begin
                model_q.push_back(expect_uop(word));
            end
            occ_m = occ_m + int'(acc_m) - int'(pop_m);
        end
        check_outputs(p);
    endtask

    task automatic drain_queue();
        int guard;
        guard = 0;
        while ((model_q.size() != 0 || out_vld_m) && guard < DRAIN_LIMIT) begin
            apply_cycle(NOP_WORD, 1'b0, 1'b0, 1'b0);
            guard++;
        end
        if (model_q.size() != 0) begin
            failures++;
            $display("queue still held %0d micro-ops after draining", model_q.size());
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] word;
        logic        p;
        logic        rs;
        logic        rob;
        int          edges;
        int          asrt_fails;

        lfsr        = 32'h41b05d59;
        occ_m       = 0;
        stg_vld_m   = 1'b0;
        out_vld_m   = 1'b0;
        mismatches  = 0;
        failures    = 0;
        issue_count = 0;
        rst         = 1'b0;
        pause       = 1'b0;
        insn        = NOP_WORD;
        rs_full     = 1'b0;
        rob_full    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // One register-form word into an empty queue
        apply_cycle({5'd3, 5'd1, 5'd2, 5'd3, 12'h000}, 1'b0, 1'b0, 1'b0);
        edges = 0;
        while (issued !== 1'b1 && edges < 8) begin
            apply_cycle(NOP_WORD, 1'b0, 1'b0, 1'b0);
            edges++;
        end
        if (edges != 2) begin
            report_mismatch($sformatf("latency %0d edges, expected 2", edges));
        end
        drain_queue();

        // Fill past capacity while the stations report full
        for (int n = 1; n <= 17; n++) begin
            apply_cycle(valid_word(), 1'b0, 1'b1, 1'b0);
            if (n == 14 && iq_full !== 1'b0) begin
                report_mismatch("iq_full high after 14 words");
            end
            if (n == 15 && iq_full !== 1'b1) begin
                report_mismatch("iq_full low after 15 words");
            end
        end
        issue_count = 0;
        drain_queue();
        if (issue_count != `DISPATCH_IQ_DEPTH) begin
            report_mismatch($sformatf("%0d micro-ops issued after overflow, expected 16",
                                      issue_count));
        end

        // Freeze with work in flight and valid words on the input
        for (int n = 0; n < 3; n++) begin
            apply_cycle(valid_word(), 1'b0, 1'b0, 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            apply_cycle(valid_word(), 1'b1, 1'b0, 1'b0);
        end
        drain_queue();

        for (int n = 0; n < RAND_WORDS; n++) begin
            word = random_word();
            if (iq_full === 1'b1) begin
                word = NOP_WORD;
            end
            p   = (next_bits(3) == 32'd0);
            rs  = (next_bits(2) == 32'd0);
            rob = (next_bits(2) == 32'd0);
            apply_cycle(word, p, rs, rob);
        end
        drain_queue();

        asrt_fails = dut_i.asrt_i.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, asrt_fails);
        if (mismatches + failures + asrt_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/dispatch_pkg.sv
rtl/insn_decoder.sv
rtl/iq_storage.sv
rtl/dispatch_ctrl.sv
rtl/issue_stage.sv
rtl/dispatch_top.sv
tests/dispatch_assertions.sv
tests/dispatch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module dispatch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vdispatch_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
